/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_id_stage.sv */
`timescale 1ns/100ps
`include "id_defs.svh"

module tb_id_stage;

	import id_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int N_FWD        = 40;
	localparam int N_CMP        = 6 * 2 * 6;
	// each compare jump costs three register loads and one strobe
	localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 32 + 8 + N_FWD + N_CMP * 4 + 16;
	localparam int TIMEOUT_NS   = (TEST_CYCLES + 100) * CLK_PERIOD;

	typedef struct packed {
		aluop_e  aluop;
		alusel_e alusel;
	} alu_exp_t;

	typedef struct packed {
		logic    valid;
		logic    chk_ops;
		logic    chk_tgt;
		ex_pkt_t pkt;
		branch_t br;
	} expect_t;

	logic    clk_i = 1'b0;
	logic    rst_n_i;
	logic    inst_valid_i;
	inst_u   inst_i;
	fwd_t    ex_fwd_i;
	fwd_t    mem_fwd_i;
	logic    ex_valid_o;
	ex_pkt_t ex_pkt_o;
	branch_t branch_o;

	logic [`ID_DATA_W-1:0] shadow [`ID_NUM_REGS];
	expect_t               exp_d;
	expect_t               exp_q;
	int                    errors = 0;
	logic [7:0] alu_ops [9] = '{`ID_OP_OR, `ID_OP_AND, `ID_OP_XOR, `ID_OP_SHL, `ID_OP_SHR,
		`ID_OP_SAR, `ID_OP_ADD, `ID_OP_SUB, `ID_OP_MOV};
	logic [7:0] cmp_ops [6] = '{`ID_OP_JE, `ID_OP_JNE, `ID_OP_JG, `ID_OP_JL, `ID_OP_JNG,
		`ID_OP_JNL};

	id_stage i_id_stage (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd_i),
		.ex_valid_o   (ex_valid_o),
		.ex_pkt_o     (ex_pkt_o),
		.branch_o     (branch_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic logic [`ID_DATA_W-1:0] rand_word();
		return $urandom;
	endfunction

	function automatic logic [`ID_RADDR_W-1:0] rand_addr();
		logic [31:0] r;
		r = $urandom;
		return r[`ID_RADDR_W-1:0];
	endfunction

	function automatic inst_u build_sreg(input logic [3:0] form, input logic [7:0] op,
			input logic [4:0] a, input logic [4:0] b, input logic [31:0] imm);
		inst_u w;
		w = '0;
		w.sreg = '{form, op, a, b, imm, 10'd0};
		return w;
	endfunction

	function automatic inst_u build_dreg(input logic [3:0] form, input logic [7:0] op,
			input logic [4:0] a, input logic [4:0] b, input logic [4:0] c);
		inst_u w;
		w = '0;
		w.dreg = '{form, op, a, b, c, 37'd0};
		return w;
	endfunction

	// {op1, op2} as random, equal, off by one or unsigned extreme pairs
	function automatic logic [63:0] operand_pair(input int mode);
		logic [31:0] x;
		x = $urandom;
		case (mode)
			0: return {x, rand_word()};
			1: return {x, x};
			2: return {x, x + 32'd1};
			3: return {x + 32'd1, x};
			4: return {32'd0, 32'hffff_ffff};
			default: return {32'hffff_ffff, 32'd0};
		endcase
	endfunction

	function automatic alu_exp_t alu_code(input logic [7:0] op);
		case (op)
			`ID_OP_OR:  return '{ALUOP_OR, SEL_LOGIC};
			`ID_OP_AND: return '{ALUOP_AND, SEL_LOGIC};
			`ID_OP_XOR: return '{ALUOP_XOR, SEL_LOGIC};
			`ID_OP_SHL: return '{ALUOP_SHL, SEL_SHIFT};
			`ID_OP_SHR: return '{ALUOP_SHR, SEL_SHIFT};
			`ID_OP_SAR: return '{ALUOP_SAR, SEL_SHIFT};
			`ID_OP_ADD: return '{ALUOP_ADD, SEL_ARITH};
			`ID_OP_SUB: return '{ALUOP_SUB, SEL_ARITH};
			`ID_OP_MOV: return '{ALUOP_MOV, SEL_MOV};
			default:    return '{ALUOP_NOP, SEL_NOP};
		endcase
	endfunction

	function automatic logic cmp_taken(input logic [7:0] op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			`ID_OP_JE:  return a == b;
			`ID_OP_JNE: return a != b;
			`ID_OP_JG:  return a > b;
			`ID_OP_JL:  return a < b;
			`ID_OP_JNG: return a <= b;
			`ID_OP_JNL: return a >= b;
			default:    return 1'b0;
		endcase
	endfunction

	// newest in-flight result first and then the architectural value
	function automatic logic [31:0] source_value(input logic [4:0] addr, input fwd_t exf,
			input fwd_t mf, input logic [31:0] regv);
		if (exf.wr_en && exf.addr == addr) return exf.data;
		if (mf.wr_en && mf.addr == addr) return mf.data;
		return regv;
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `ID_NUM_REGS; i++) begin
				shadow[i] <= '0;
			end
		end else if (mem_fwd_i.wr_en) begin
			shadow[mem_fwd_i.addr] <= mem_fwd_i.data;
		end
	end

	// reference model for the strobe in this cycle
	always_comb begin
		alu_exp_t    alu;
		logic        is_s;
		logic        is_d;
		logic        is_cmp;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vc;
		alu    = alu_code(inst_i.sreg.op);
		is_s   = inst_i.sreg.form == `ID_FORM_SREG;
		is_d   = inst_i.sreg.form == `ID_FORM_DREG;
		is_cmp = inst_i.sreg.op >= `ID_OP_JE && inst_i.sreg.op <= `ID_OP_JNL;
		va     = source_value(inst_i.sreg.field_a, ex_fwd_i, mem_fwd_i,
			shadow[inst_i.sreg.field_a]);
		vb     = source_value(inst_i.sreg.field_b, ex_fwd_i, mem_fwd_i,
			shadow[inst_i.sreg.field_b]);
		vc     = source_value(inst_i.dreg.field_c, ex_fwd_i, mem_fwd_i,
			shadow[inst_i.dreg.field_c]);
		exp_d  = '0;
		if (inst_valid_i) begin
			exp_d.valid = 1'b1;
			if (is_s && alu.aluop != ALUOP_NOP && alu.aluop != ALUOP_MOV) begin
				exp_d.pkt     = '{alu.aluop, alu.alusel, vb, inst_i.sreg.imm,
					inst_i.sreg.field_a, 1'b1};
				exp_d.chk_ops = 1'b1;
			end else if (is_d && alu.aluop != ALUOP_NOP) begin
				exp_d.pkt     = '{alu.aluop, alu.alusel, vb,
					(alu.aluop == ALUOP_MOV) ? 32'd0 : vc, inst_i.dreg.field_a, 1'b1};
				exp_d.chk_ops = 1'b1;
			end else if (is_cmp && (is_s || is_d)) begin
				exp_d.pkt.aluop  = ALUOP_JUMP;
				exp_d.pkt.alusel = SEL_JUMP;
				exp_d.pkt.op1    = va;
				exp_d.pkt.op2    = vb;
				exp_d.br.taken   = cmp_taken(inst_i.sreg.op, va, vb);
				exp_d.br.target  = is_s ? inst_i.sreg.imm : vc;
				exp_d.chk_ops    = 1'b1;
				exp_d.chk_tgt    = 1'b1;
			end else if (is_d && inst_i.sreg.op == `ID_OP_JMP) begin
				exp_d.pkt.aluop  = ALUOP_JUMP;
				exp_d.pkt.alusel = SEL_JUMP;
				exp_d.br.taken   = 1'b1;
				exp_d.br.target  = vb;
				exp_d.chk_tgt    = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exp_q <= '0;
		end else begin
			exp_q <= exp_d;
		end
	end

	task automatic flag_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] want);
		errors++;
		$display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, want);
	endtask

	a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ex_valid_o == exp_q.valid)
		else flag_mismatch("ex_valid_o", 64'($sampled(ex_valid_o)), 64'($sampled(exp_q.valid)));
	a_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		branch_o.taken == exp_q.br.taken)
		else flag_mismatch("taken", 64'($sampled(branch_o.taken)), 64'($sampled(exp_q.br.taken)));
	a_ctrl: assert property (@(posedge clk_i) disable iff (!rst_n_i) exp_q.valid |->
		{ex_pkt_o.aluop, ex_pkt_o.alusel, ex_pkt_o.wr_en} ==
		{exp_q.pkt.aluop, exp_q.pkt.alusel, exp_q.pkt.wr_en})
		else flag_mismatch("aluop/alusel/wr_en",
			64'($sampled({ex_pkt_o.aluop, ex_pkt_o.alusel, ex_pkt_o.wr_en})),
			64'($sampled({exp_q.pkt.aluop, exp_q.pkt.alusel, exp_q.pkt.wr_en})));
	a_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		exp_q.valid && exp_q.pkt.wr_en |-> ex_pkt_o.rd == exp_q.pkt.rd)
		else flag_mismatch("rd", 64'($sampled(ex_pkt_o.rd)), 64'($sampled(exp_q.pkt.rd)));
	a_ops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		exp_q.chk_ops |-> {ex_pkt_o.op1, ex_pkt_o.op2} == {exp_q.pkt.op1, exp_q.pkt.op2})
		else flag_mismatch("op1/op2", $sampled({ex_pkt_o.op1, ex_pkt_o.op2}),
			$sampled({exp_q.pkt.op1, exp_q.pkt.op2}));
	a_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		exp_q.chk_tgt |-> branch_o.target == exp_q.br.target)
		else flag_mismatch("target", 64'($sampled(branch_o.target)),
			64'($sampled(exp_q.br.target)));

	task automatic idle();
		@(posedge clk_i);
		inst_valid_i <= 1'b0;
		ex_fwd_i     <= '0;
		mem_fwd_i    <= '0;
	endtask

	task automatic load_reg(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk_i);
		inst_valid_i <= 1'b0;
		ex_fwd_i     <= '0;
		mem_fwd_i    <= fwd_t'{1'b1, addr, data};
	endtask

	task automatic issue(input inst_u w, input fwd_t exf, input fwd_t mf);
		@(posedge clk_i);
		inst_valid_i <= 1'b1;
		inst_i       <= w;
		ex_fwd_i     <= exf;
		mem_fwd_i    <= mf;
	endtask

	initial begin
		fwd_t        exf;
		fwd_t        mf;
		logic [4:0]  a;
		logic [4:0]  b;
		logic [4:0]  c;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] r;
		void'($urandom(74674));
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		ex_fwd_i     = '0;
		mem_fwd_i    = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
		idle();
		idle();
		// sources read zero before any write
		issue(build_sreg(`ID_FORM_SREG, `ID_OP_ADD, 5'd1, 5'd5, rand_word()), '0, '0);
		issue(build_dreg(`ID_FORM_DREG, `ID_OP_OR, 5'd2, 5'd7, 5'd9), '0, '0);
		idle();
		for (int i = 0; i < `ID_NUM_REGS; i++) begin
			load_reg(5'(i), rand_word());
		end
		for (int i = 0; i < 8; i++) begin
			issue(build_sreg(`ID_FORM_SREG, alu_ops[i], rand_addr(), rand_addr(), rand_word()),
				'0, '0);
		end
		for (int i = 0; i < N_FWD; i++) begin
			a   = rand_addr();
			b   = rand_addr();
			c   = rand_addr();
			r   = $urandom;
			exf = fwd_t'{r[0], r[1] ? b : c, rand_word()};
			mf  = fwd_t'{r[2], r[3] ? c : b, rand_word()};
			// both stages hit the same register now and then
			if (r[5:4] == 2'b00) begin
				mf.addr = exf.addr;
			end
			issue(build_dreg(`ID_FORM_DREG, alu_ops[i % 9], a, b, c), exf, mf);
		end
		for (int k = 0; k < 6; k++) begin
			for (int f = 0; f < 2; f++) begin
				for (int m = 0; m < 6; m++) begin
					{v1, v2} = operand_pair(m);
					a        = rand_addr();
					b        = a + 5'd1;
					c        = a + 5'd2;
					load_reg(a, v1);
					load_reg(b, v2);
					load_reg(c, rand_word());
					if (f == 0) begin
						issue(build_sreg(`ID_FORM_SREG, cmp_ops[k], a, b, rand_word()), '0, '0);
					end else begin
						issue(build_dreg(`ID_FORM_DREG, cmp_ops[k], a, b, c), '0, '0);
					end
				end
			end
		end
		b = rand_addr();
		load_reg(b, rand_word());
		issue(build_dreg(`ID_FORM_DREG, `ID_OP_JMP, rand_addr(), b, rand_addr()), '0, '0);
		issue(build_dreg(`ID_FORM_DREG, `ID_OP_JMP, 5'd3, 5'd4, 5'd5),
			fwd_t'{1'b1, 5'd4, rand_word()}, '0);
		// these all decode to nop
		issue(build_sreg(`ID_FORM_SREG, `ID_OP_JMP, 5'd1, 5'd2, rand_word()), '0, '0);
		issue(build_sreg(`ID_FORM_SREG, `ID_OP_MOV, 5'd1, 5'd2, rand_word()), '0, '0);
		issue(build_sreg(`ID_FORM_SREG, 8'hee, 5'd1, 5'd2, rand_word()), '0, '0);
		issue(build_dreg(`ID_FORM_DREG, 8'h00, 5'd1, 5'd2, 5'd3), '0, '0);
		issue(build_dreg(4'h7, `ID_OP_ADD, 5'd1, 5'd2, 5'd3), '0, '0);
		idle();
		idle();
		idle();
		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, the stimulus never finished", TIMEOUT_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* hw/id_branch_unit.sv */
`timescale 1ns/100ps
`include "id_defs.svh"

module id_branch_unit (
	input  id_pkg::br_kind_e            br_kind_i,
	input  logic [`ID_DATA_W-1:0]       op1_i,
	input  logic [`ID_DATA_W-1:0]       op2_i,
	input  logic [`ID_DATA_W-1:0]       op3_i,
	output id_pkg::branch_t             branch_o
);

	import id_pkg::*;

	logic [`ID_DATA_W:0] diff;
	logic                eq;
	logic                lt;

	// borrow out of op1 - op2 means op1 < op2, unsigned
	assign diff = {1'b0, op1_i} - {1'b0, op2_i};
	assign eq   = (diff == '0);
	assign lt   = diff[`ID_DATA_W];

	always_comb begin
		branch_o.taken  = 1'b0;
		branch_o.target = op3_i;
		case (br_kind_i)
			BR_JMP: begin
				branch_o.taken  = 1'b1;
				branch_o.target = op1_i;
			end
			BR_JE:  branch_o.taken = eq;
			BR_JNE: branch_o.taken = !eq;
			BR_JG:  branch_o.taken = !lt && !eq;
			BR_JL:  branch_o.taken = lt;
			BR_JNG: branch_o.taken = lt || eq;
			BR_JNL: branch_o.taken = !lt;
			default: ;
		endcase
	end

endmodule

/* hw/id_decoder.sv */
`timescale 1ns/100ps
`include "id_defs.svh"

module id_decoder (
	input  id_pkg::inst_u                 inst_i,
	output id_pkg::aluop_e                aluop_o,
	output id_pkg::alusel_e               alusel_o,
	output logic [`ID_RADDR_W-1:0]        rd_o,
	output logic                          wr_en_o,
	output id_pkg::rd_req_t [2:0]         rd_req_o,
	output logic [`ID_DATA_W-1:0]         imm_o,
	output id_pkg::br_kind_e              br_kind_o
);

	import id_pkg::*;

	aluop_e   op_aluop;
	alusel_e  op_alusel;
	br_kind_e op_br;
	logic     is_alu;
	logic     is_cmp;

	// opcode class, shared by both forms
	always_comb begin
		op_aluop  = ALUOP_NOP;
		op_alusel = SEL_NOP;
		op_br     = BR_NONE;
		case (inst_i.sreg.op)
			`ID_OP_OR:  begin op_aluop = ALUOP_OR;  op_alusel = SEL_LOGIC; end
			`ID_OP_AND: begin op_aluop = ALUOP_AND; op_alusel = SEL_LOGIC; end
			`ID_OP_XOR: begin op_aluop = ALUOP_XOR; op_alusel = SEL_LOGIC; end
			`ID_OP_SHL: begin op_aluop = ALUOP_SHL; op_alusel = SEL_SHIFT; end
			`ID_OP_SHR: begin op_aluop = ALUOP_SHR; op_alusel = SEL_SHIFT; end
			`ID_OP_SAR: begin op_aluop = ALUOP_SAR; op_alusel = SEL_SHIFT; end
			`ID_OP_ADD: begin op_aluop = ALUOP_ADD; op_alusel = SEL_ARITH; end
			`ID_OP_SUB: begin op_aluop = ALUOP_SUB; op_alusel = SEL_ARITH; end
			`ID_OP_MOV: begin op_aluop = ALUOP_MOV; op_alusel = SEL_MOV;   end
			`ID_OP_JMP: op_br = BR_JMP;
			`ID_OP_JE:  op_br = BR_JE;
			`ID_OP_JNE: op_br = BR_JNE;
			`ID_OP_JG:  op_br = BR_JG;
			`ID_OP_JL:  op_br = BR_JL;
			`ID_OP_JNG: op_br = BR_JNG;
			`ID_OP_JNL: op_br = BR_JNL;
			default: ;
		endcase
	end

	assign is_alu = (op_alusel != SEL_NOP);
	assign is_cmp = (op_br != BR_NONE) && (op_br != BR_JMP);

	always_comb begin
		aluop_o   = ALUOP_NOP;
		alusel_o  = SEL_NOP;
		rd_o      = '0;
		wr_en_o   = 1'b0;
		rd_req_o  = '0;
		imm_o     = '0;
		br_kind_o = BR_NONE;
		case (inst_i.sreg.form)
			`ID_FORM_SREG: begin
				if (is_alu && op_aluop != ALUOP_MOV) begin
					aluop_o     = op_aluop;
					alusel_o    = op_alusel;
					rd_o        = inst_i.sreg.field_a;
					wr_en_o     = 1'b1;
					rd_req_o[0] = {1'b1, inst_i.sreg.field_b};
					imm_o       = inst_i.sreg.imm;
				end else if (is_cmp) begin
					aluop_o     = ALUOP_JUMP;
					alusel_o    = SEL_JUMP;
					br_kind_o   = op_br;
					rd_req_o[0] = {1'b1, inst_i.sreg.field_a};
					rd_req_o[1] = {1'b1, inst_i.sreg.field_b};
					// path 3 falls back to imm as the target
					imm_o       = inst_i.sreg.imm;
				end
			end
			`ID_FORM_DREG: begin
				if (is_alu) begin
					aluop_o     = op_aluop;
					alusel_o    = op_alusel;
					rd_o        = inst_i.dreg.field_a;
					wr_en_o     = 1'b1;
					rd_req_o[0] = {1'b1, inst_i.dreg.field_b};
					// mov has one source, op2 becomes the zero imm
					rd_req_o[1] = {op_aluop != ALUOP_MOV, inst_i.dreg.field_c};
				end else if (op_br == BR_JMP) begin
					aluop_o     = ALUOP_JUMP;
					alusel_o    = SEL_JUMP;
					br_kind_o   = BR_JMP;
					rd_req_o[0] = {1'b1, inst_i.dreg.field_b};
				end else if (is_cmp) begin
					aluop_o     = ALUOP_JUMP;
					alusel_o    = SEL_JUMP;
					br_kind_o   = op_br;
					rd_req_o[0] = {1'b1, inst_i.dreg.field_a};
					rd_req_o[1] = {1'b1, inst_i.dreg.field_b};
					rd_req_o[2] = {1'b1, inst_i.dreg.field_c};
				end
			end
			default: ;
		endcase
	end

endmodule

/* hw/id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath sizes
`define ID_DATA_W    32
`define ID_INST_W    64
`define ID_RADDR_W   5
`define ID_NUM_REGS  32

// instruction form, bits 63:60
`define ID_FORM_SREG 4'h1
`define ID_FORM_DREG 4'h2

// opcodes, bits 59:52
`define ID_OP_OR     8'h01
`define ID_OP_AND    8'h02
`define ID_OP_XOR    8'h03
`define ID_OP_SHL    8'h05
`define ID_OP_SHR    8'h06
`define ID_OP_SAR    8'h07
`define ID_OP_MOV    8'h08
`define ID_OP_ADD    8'h10
`define ID_OP_SUB    8'h11
`define ID_OP_JMP    8'h20
`define ID_OP_JE     8'h21
`define ID_OP_JNE    8'h22
`define ID_OP_JG     8'h23
`define ID_OP_JL     8'h24
`define ID_OP_JNG    8'h25
`define ID_OP_JNL    8'h26

`endif

/* hw/id_operand_fwd.sv */
`timescale 1ns/100ps
`include "id_defs.svh"

module id_operand_fwd (
	input  id_pkg::rd_req_t             req_i,
	input  id_pkg::fwd_t                ex_fwd_i,
	input  id_pkg::fwd_t                mem_fwd_i,
	input  logic [`ID_DATA_W-1:0]       reg_data_i,
	input  logic [`ID_DATA_W-1:0]       imm_i,
	output logic [`ID_DATA_W-1:0]       operand_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_fwd_i.wr_en && (ex_fwd_i.addr == req_i.addr);
	assign mem_hit = mem_fwd_i.wr_en && (mem_fwd_i.addr == req_i.addr);

	// youngest result wins
	always_comb begin
		if (!req_i.en) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.data;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.data;
		end else begin
			operand_o = reg_data_i;
		end
	end

endmodule

/* hw/id_pkg.sv */
`include "id_defs.svh"

package id_pkg;

	// register-immediate layout
	typedef struct packed {
		logic [3:0]               form;
		logic [7:0]               op;
		logic [`ID_RADDR_W-1:0]   field_a;
		logic [`ID_RADDR_W-1:0]   field_b;
		logic [`ID_DATA_W-1:0]    imm;
		logic [9:0]               pad;
	} inst_sreg_t;

	// three-register layout
	typedef struct packed {
		logic [3:0]               form;
		logic [7:0]               op;
		logic [`ID_RADDR_W-1:0]   field_a;
		logic [`ID_RADDR_W-1:0]   field_b;
		logic [`ID_RADDR_W-1:0]   field_c;
		logic [36:0]              pad;
	} inst_dreg_t;

	typedef union packed {
		inst_sreg_t sreg;
		inst_dreg_t dreg;
	} inst_u;

	typedef struct packed {
		logic                     wr_en;
		logic [`ID_RADDR_W-1:0]   addr;
		logic [`ID_DATA_W-1:0]    data;
	} fwd_t;

	typedef struct packed {
		logic                     en;
		logic [`ID_RADDR_W-1:0]   addr;
	} rd_req_t;

	typedef enum logic [3:0] {
		ALUOP_NOP, ALUOP_OR, ALUOP_AND, ALUOP_XOR, ALUOP_SHL, ALUOP_SHR,
		ALUOP_SAR, ALUOP_ADD, ALUOP_SUB, ALUOP_MOV, ALUOP_JUMP
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOV, SEL_JUMP
	} alusel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_JMP, BR_JE, BR_JNE, BR_JG, BR_JL, BR_JNG, BR_JNL
	} br_kind_e;

	typedef struct packed {
		aluop_e                   aluop;
		alusel_e                  alusel;
		logic [`ID_DATA_W-1:0]    op1;
		logic [`ID_DATA_W-1:0]    op2;
		logic [`ID_RADDR_W-1:0]   rd;
		logic                     wr_en;
	} ex_pkt_t;

	typedef struct packed {
		logic                     taken;
		logic [`ID_DATA_W-1:0]    target;
	} branch_t;

endpackage

/* hw/id_regfile.sv */
`timescale 1ns/100ps
`include "id_defs.svh"

module id_regfile (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  id_pkg::rd_req_t [2:0]             rd_req_i,
	input  id_pkg::fwd_t                      wr_i,
	output logic [2:0][`ID_DATA_W-1:0]        rd_data_o
);

	logic [`ID_DATA_W-1:0] regs [`ID_NUM_REGS];

	// single write port, fed by the memory stage
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `ID_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_i.wr_en) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// enables only matter in the operand paths
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			rd_data_o[i] = regs[rd_req_i[i].addr];
		end
	end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/100ps
`include "id_defs.svh"

module id_stage (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                inst_valid_i,
	input  id_pkg::inst_u       inst_i,
	input  id_pkg::fwd_t        ex_fwd_i,
	input  id_pkg::fwd_t        mem_fwd_i,
	output logic                ex_valid_o,
	output id_pkg::ex_pkt_t     ex_pkt_o,
	output id_pkg::branch_t     branch_o
);

	import id_pkg::*;

	aluop_e                        aluop;
	alusel_e                       alusel;
	br_kind_e                      br_kind;
	logic [`ID_RADDR_W-1:0]        rd;
	logic                          wr_en;
	rd_req_t [2:0]                 rd_req;
	logic [`ID_DATA_W-1:0]         imm;
	logic [2:0][`ID_DATA_W-1:0]    rd_data;
	logic [2:0][`ID_DATA_W-1:0]    operand;
	branch_t                       br_d;
	ex_pkt_t                       pkt_d;
	logic                          taken_q;
	logic [`ID_DATA_W-1:0]         target_q;

	id_decoder i_id_decoder (
		.inst_i    (inst_i),
		.aluop_o   (aluop),
		.alusel_o  (alusel),
		.rd_o      (rd),
		.wr_en_o   (wr_en),
		.rd_req_o  (rd_req),
		.imm_o     (imm),
		.br_kind_o (br_kind)
	);

	id_regfile i_id_regfile (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.rd_req_i  (rd_req),
		.wr_i      (mem_fwd_i),
		.rd_data_o (rd_data)
	);

	for (genvar g = 0; g < 3; g++) begin : g_operand
		id_operand_fwd i_id_operand_fwd (
			.req_i      (rd_req[g]),
			.ex_fwd_i   (ex_fwd_i),
			.mem_fwd_i  (mem_fwd_i),
			.reg_data_i (rd_data[g]),
			.imm_i      (imm),
			.operand_o  (operand[g])
		);
	end

	id_branch_unit i_id_branch_unit (
		.br_kind_i (br_kind),
		.op1_i     (operand[0]),
		.op2_i     (operand[1]),
		.op3_i     (operand[2]),
		.branch_o  (br_d)
	);

	assign pkt_d = '{aluop: aluop, alusel: alusel, op1: operand[0], op2: operand[1],
			rd: rd, wr_en: wr_en};

	// ID/EX control bits
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid_o <= 1'b0;
			taken_q    <= 1'b0;
		end else begin
			ex_valid_o <= inst_valid_i;
			taken_q    <= inst_valid_i && br_d.taken;
		end
	end

	// ID/EX payload, loaded on strobe
	always_ff @(posedge clk_i) begin
		if (inst_valid_i) begin
			ex_pkt_o <= pkt_d;
			target_q <= br_d.target;
		end
	end

	assign branch_o = '{taken: taken_q, target: target_q};

endmodule

/* tb.f */
+incdir+hw
hw/id_pkg.sv
hw/id_regfile.sv
hw/id_decoder.sv
hw/id_operand_fwd.sv
hw/id_branch_unit.sv
hw/id_stage.sv
dv/tb_id_stage.sv
